// File: src.f
common/pi1_pkg.sv
logic/pi1_buffer.sv
pi1_to_wb4/pi1_to_wb4.sv
logic/wb4_ram.sv
logic/pi1_top.sv
bench/tb_pi1_top.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_pi1_top
RTL_TOP    = pi1_top
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	elif grep -q "All tests passed" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_pi1_top.sv
// ********************
// Pi1 bridge testbench
// ********************

`timescale 1ns/1ps

module tb_pi1_top;

	import pi1_pkg::*;

	localparam int RDY_TIMEOUT = 50;
	localparam int RANDOM_OPS  = 2000;

	logic                 clk_i;
	logic                 rst_i;
	pi1_req_t             pi1_req_i;
	logic [ARCH_BITS-1:0] pi1_data_o;
	logic                 pi1_rdy_o;

	logic [ARCH_BITS-1:0] model_mem [RAM_WORDS];
	logic [ARCH_BITS-1:0] exp_data_q [$];
	bit                   exp_check_q [$];
	string                exp_name_q [$];
	logic [31:0]          rng;
	string                test_name;
	int                   op_count;

	pi1_top u_dut (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pi1_req_i  (pi1_req_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o)
	);

	always #5 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic [SEL_BITS-1:0] random_sel();
		logic [31:0] r;
		r = next_random();
		return (r[SEL_BITS-1:0] == '0) ? '1 : r[SEL_BITS-1:0]; // Never all clear.
	endfunction

	function automatic logic [RAM_ADDR_BITS-1:0] random_addr();
		logic [31:0] r;
		r = next_random();
		return r[RAM_ADDR_BITS-1:0];
	endfunction

	function automatic pi1_req_t make_req(input pi1_op_e op,
		input logic [RAM_ADDR_BITS-1:0] addr, input logic [ARCH_BITS-1:0] data,
		input logic [SEL_BITS-1:0] sel);
		pi1_req_t req;
		req.op                      = op;
		req.addr                    = '0;
		req.addr[RAM_ADDR_BITS-1:0] = addr;
		req.data                    = data;
		req.sel                     = sel;
		return req;
	endfunction

	function automatic pi1_req_t random_req();
		logic [31:0] r;
		r = next_random();
		return make_req(pi1_op_e'(r[1:0]), r[9:2], next_random(), random_sel());
	endfunction

	// Initial memory image that differs for every word.
	function automatic logic [ARCH_BITS-1:0] fill_word(input logic [RAM_ADDR_BITS-1:0] a);
		return {a, ~a, a ^ 8'h5a, a + 8'h3c};
	endfunction

	function automatic logic [ARCH_BITS-1:0] merge_bytes(input logic [ARCH_BITS-1:0] old,
		input logic [ARCH_BITS-1:0] data, input logic [SEL_BITS-1:0] sel);
		logic [ARCH_BITS-1:0] word;
		word = old;
		for (int i = 0; i < SEL_BITS; i++) begin
			if (sel[i]) begin
				word[i*8 +: 8] = data[i*8 +: 8];
			end
		end
		return word;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [ARCH_BITS-1:0] expected,
		input logic [ARCH_BITS-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %s: expected %08h, actual %08h",
				name, expected, actual));
		end
	endtask

	// Result of a request is fixed by the model when the request is taken.
	task automatic model_take(input pi1_req_t req);
		logic [RAM_ADDR_BITS-1:0] idx;
		logic [ARCH_BITS-1:0]     old;
		idx = req.addr[RAM_ADDR_BITS-1:0];
		old = model_mem[idx];
		case (req.op)
			PI_NOP: begin
				exp_check_q.push_back(1'b1);
				exp_data_q.push_back('0);
			end
			PI_WR: begin
				exp_check_q.push_back(1'b0); // Data on a write ack is don't care.
				exp_data_q.push_back('0);
				model_mem[idx] = merge_bytes(old, req.data, req.sel);
			end
			PI_RD: begin
				exp_check_q.push_back(1'b1);
				exp_data_q.push_back(old);
			end
			PI_RW: begin
				exp_check_q.push_back(1'b1);
				exp_data_q.push_back(old);
				model_mem[idx] = merge_bytes(old, req.data, req.sel);
			end
		endcase
		exp_name_q.push_back(test_name);
	endtask

	// Present one request and hold it until a rdy-high edge takes it.
	task automatic transfer(input pi1_req_t req, output int waits);
		logic [ARCH_BITS-1:0] exp_data;
		bit                   exp_check;
		string                exp_name;
		waits = 0;
		pi1_req_i <= req;
		@(negedge clk_i);
		while (!pi1_rdy_o && waits < RDY_TIMEOUT) begin
			waits++;
			@(negedge clk_i);
		end
		if (!pi1_rdy_o) begin
			abort_run($sformatf("Timeout in %s: pi1_rdy_o never returned within %0d cycles",
				test_name, RDY_TIMEOUT));
		end else begin
			// Data here belongs to the request taken two rdy edges back.
			exp_data  = exp_data_q.pop_front();
			exp_check = exp_check_q.pop_front();
			exp_name  = exp_name_q.pop_front();
			if (exp_check) begin
				check_value(exp_name, exp_data, pi1_data_o);
			end
			model_take(req);
			op_count++;
			@(posedge clk_i);
		end
	endtask

	initial begin
		int                       waits;
		logic [RAM_ADDR_BITS-1:0] addr;
		clk_i     = 1'b0;
		rst_i     = 1'b1;
		pi1_req_i = '0;
		rng       = 32'h9491_7131;
		op_count  = 0;
		test_name = "reset";

		// Bridge and buffer are both idle out of reset.
		repeat (2) begin
			exp_check_q.push_back(1'b1);
			exp_data_q.push_back('0);
			exp_name_q.push_back(test_name);
		end

		repeat (8) @(posedge clk_i);
		rst_i <= 1'b0;

		test_name = "nop_idle";
		for (int i = 0; i < 16; i++) begin
			transfer(make_req(PI_NOP, '0, next_random(), random_sel()), waits);
			check_value("nop_rdy_wait", 0, waits);
		end

		test_name = "fill";
		for (int i = 0; i < RAM_WORDS; i++) begin
			addr = i[RAM_ADDR_BITS-1:0];
			transfer(make_req(PI_WR, addr, fill_word(addr), '1), waits);
		end

		test_name = "write_read";
		for (int i = 0; i < 16; i++) begin
			addr = random_addr();
			transfer(make_req(PI_WR, addr, next_random(), random_sel()), waits);
			transfer(make_req(PI_RD, addr, next_random(), random_sel()), waits);
		end

		test_name = "swap";
		for (int i = 0; i < 16; i++) begin
			addr = random_addr();
			transfer(make_req(PI_RW, addr, next_random(), random_sel()), waits);
			transfer(make_req(PI_RD, addr, next_random(), random_sel()), waits);
		end

		test_name = "burst_writes";
		for (int i = 0; i < 32; i++) begin
			addr = 8'h40 + i[RAM_ADDR_BITS-1:0];
			transfer(make_req(PI_WR, addr, next_random(), random_sel()), waits);
		end
		for (int i = 0; i < 32; i++) begin
			addr = 8'h40 + i[RAM_ADDR_BITS-1:0];
			transfer(make_req(PI_RD, addr, next_random(), random_sel()), waits);
		end

		test_name = "random_mix";
		for (int i = 0; i < RANDOM_OPS; i++) begin
			transfer(random_req(), waits);
		end

		// Two no-ops flush the last real results through.
		test_name = "drain";
		repeat (2) transfer(make_req(PI_NOP, '0, '0, '1), waits);

		@(negedge clk_i);
		if (!pi1_rdy_o) begin
			abort_run("Bridge still busy after the final no-ops");
		end else begin
			$display("%0d operations completed", op_count);
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: logic/pi1_top.sv
// ********************
// Pi1 bridge top
// ********************

`timescale 1ns/1ps

module pi1_top (
	input  logic                          clk_i,
	input  logic                          rst_i,

	input  pi1_pkg::pi1_req_t             pi1_req_i,
	output logic [pi1_pkg::ARCH_BITS-1:0] pi1_data_o,
	output logic                          pi1_rdy_o
);

	import pi1_pkg::*;

	// Internal Wishbone bus.
	logic                   wb4_cyc;
	logic                   wb4_stb;
	wb4_req_t               wb4_req;
	logic                   wb4_stall;
	logic                   wb4_ack;
	logic [ARCH_BITS-1:0]   wb4_rdata;

	pi1_to_wb4 u_bridge (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_req_i   (pi1_req_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.wb4_cyc_o   (wb4_cyc),
		.wb4_stb_o   (wb4_stb),
		.wb4_req_o   (wb4_req),
		.wb4_stall_i (wb4_stall),
		.wb4_ack_i   (wb4_ack),
		.wb4_data_i  (wb4_rdata)
	);

	wb4_ram u_ram (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.wb4_cyc_i   (wb4_cyc),
		.wb4_stb_i   (wb4_stb),
		.wb4_req_i   (wb4_req),
		.wb4_stall_o (wb4_stall),
		.wb4_ack_o   (wb4_ack),
		.wb4_data_o  (wb4_rdata)
	);

endmodule

// File: logic/wb4_ram.sv
// ********************
// Wishbone B4 memory
// ********************

`timescale 1ns/1ps

module wb4_ram (
	input  logic                          clk_i,
	input  logic                          rst_i,

	input  logic                          wb4_cyc_i,
	input  logic                          wb4_stb_i,
	input  pi1_pkg::wb4_req_t             wb4_req_i,
	output logic                          wb4_stall_o,
	output logic                          wb4_ack_o,
	output logic [pi1_pkg::ARCH_BITS-1:0] wb4_data_o
);

	import pi1_pkg::*;

	logic [ARCH_BITS-1:0]       mem [RAM_WORDS];
	logic [RAM_ADDR_BITS-1:0]   idx;
	logic                       accept;
	logic                       stall_q;
	logic                       ack_q;
	logic [ARCH_BITS-1:0]       rd_q;

	assign idx    = wb4_req_i.addr[RAM_ADDR_BITS+1:2]; // Word index.
	assign accept = wb4_cyc_i && wb4_stb_i && !stall_q;

	// Storage, one byte lane per select.
	always_ff @(posedge clk_i) begin
		if (accept) begin
			if (wb4_req_i.we) begin
				for (int i = 0; i < SEL_BITS; i++) begin
					if (wb4_req_i.sel[i]) begin
						mem[idx][i*8 +: 8] <= wb4_req_i.data[i*8 +: 8];
					end
				end
			end else begin
				rd_q <= mem[idx];
			end
		end
	end

	// Ack one cycle after acceptance; a write also costs one stall cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q   <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			ack_q   <= accept;
			stall_q <= accept && wb4_req_i.we; // Write recovery.
		end
	end

	assign wb4_stall_o = stall_q;
	assign wb4_ack_o   = ack_q;
	assign wb4_data_o  = rd_q;

	a_ack_follows: assert property (
		@(posedge clk_i) disable iff (rst_i)
		wb4_ack_o |-> $past(accept)
	);

	// The master keeps its cycle open until the last ack.
	a_ack_in_cyc: assert property (
		@(posedge clk_i) disable iff (rst_i)
		wb4_ack_o |-> wb4_cyc_i
	);

endmodule

// File: pi1_to_wb4/pi1_to_wb4.sv
// ********************
// Pi1 to Wishbone B4
// ********************

`timescale 1ns/1ps

module pi1_to_wb4 (
	input  logic                          clk_i,
	input  logic                          rst_i,

	// pi1 port, registered internally.
	input  pi1_pkg::pi1_req_t             pi1_req_i,
	output logic [pi1_pkg::ARCH_BITS-1:0] pi1_data_o,
	output logic                          pi1_rdy_o,

	// Wishbone B4 pipelined master.
	output logic                          wb4_cyc_o,
	output logic                          wb4_stb_o,
	output pi1_pkg::wb4_req_t             wb4_req_o,
	input  logic                          wb4_stall_i,
	input  logic                          wb4_ack_i,
	input  logic [pi1_pkg::ARCH_BITS-1:0] wb4_data_i
);

	import pi1_pkg::*;

	pi1_req_t                         buf_req;
	logic [ARCH_BITS-1:0]             buf_data;
	logic                             buf_rdy;

	logic                             wr_pending;
	pi1_op_e                          op_q;
	logic [ARCH_BITS-1:0]             rd_hold;
	logic                             last_ack;

	logic [ARCH_BITS-ADDR_BITS-1:0]   byte_off;
	logic [ARCH_BITS-1:0]             addr_w;

	pi1_buffer u_buffer (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.m_req_i  (pi1_req_i),
		.m_data_o (pi1_data_o),
		.m_rdy_o  (pi1_rdy_o),
		.s_req_o  (buf_req),
		.s_data_i (buf_data),
		.s_rdy_i  (buf_rdy)
	);

	// Lowest set select picks the byte offset.
	always_comb begin
		byte_off = '0;
		for (int i = SEL_BITS - 1; i >= 0; i--) begin
			if (buf_req.sel[i]) begin
				byte_off = i[ARCH_BITS-ADDR_BITS-1:0];
			end
		end
	end

	assign addr_w = {buf_req.addr, byte_off};

	// Final ack of an operation: a swap's read ack does not count.
	assign last_ack = wb4_ack_i && !wr_pending;

	assign buf_rdy  = !wb4_cyc_o || last_ack;
	assign buf_data = last_ack ? ((op_q == PI_RW) ? rd_hold : wb4_data_i) : '0;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb4_cyc_o  <= 1'b0;
			wb4_stb_o  <= 1'b0;
			wr_pending <= 1'b0;
		end else if (buf_rdy) begin
			op_q           <= buf_req.op;
			wb4_req_o.addr <= addr_w;
			wb4_req_o.data <= buf_req.data;
			wb4_req_o.sel  <= buf_req.sel;
			case (buf_req.op)
				PI_RD: begin
					wb4_cyc_o    <= 1'b1;
					wb4_stb_o    <= 1'b1;
					wb4_req_o.we <= 1'b0;
				end
				PI_WR: begin
					wb4_cyc_o    <= 1'b1;
					wb4_stb_o    <= 1'b1;
					wb4_req_o.we <= 1'b1;
				end
				PI_RW: begin
					wb4_cyc_o    <= 1'b1;
					wb4_stb_o    <= 1'b1;
					wb4_req_o.we <= 1'b0; // Read phase first.
					wr_pending   <= 1'b1;
				end
				default: begin
					wb4_cyc_o    <= 1'b0;
					wb4_stb_o    <= 1'b0;
					wb4_req_o.we <= 1'b0;
				end
			endcase
		end else if (wr_pending && wb4_ack_i) begin
			rd_hold      <= wb4_data_i; // Old word for the swap.
			wb4_stb_o    <= 1'b1;
			wb4_req_o.we <= 1'b1;
			wr_pending   <= 1'b0;
		end else if (!wb4_stall_i) begin
			wb4_stb_o <= 1'b0; // Request accepted.
		end
	end

	a_stb_in_cyc: assert property (
		@(posedge clk_i) disable iff (rst_i)
		wb4_stb_o |-> wb4_cyc_o
	);

	// A stalled request stays on the bus unchanged.
	a_stall_hold: assert property (
		@(posedge clk_i) disable iff (rst_i)
		wb4_stb_o && wb4_stall_i |=> wb4_stb_o && $stable(wb4_req_o)
	);

endmodule

// File: logic/pi1_buffer.sv
// ********************
// Pi1 request stage
// ********************

`timescale 1ns/1ps

module pi1_buffer (
	input  logic                          clk_i,
	input  logic                          rst_i,

	// Master side.
	input  pi1_pkg::pi1_req_t             m_req_i,
	output logic [pi1_pkg::ARCH_BITS-1:0] m_data_o,
	output logic                          m_rdy_o,

	// Slave side, toward the bridge.
	output pi1_pkg::pi1_req_t             s_req_o,
	input  logic [pi1_pkg::ARCH_BITS-1:0] s_data_i,
	input  logic                          s_rdy_i
);

	import pi1_pkg::*;

	pi1_req_t req_q;

	// The slave takes the registered request whenever it is ready, so
	// the master is loaded on exactly those cycles as well.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q.op <= PI_NOP; // Idle after reset.
		end else if (s_rdy_i) begin
			req_q <= m_req_i;
		end
	end

	assign s_req_o = req_q;

	// Handshake and read data go straight back to the master.
	assign m_rdy_o  = s_rdy_i;
	assign m_data_o = s_data_i;

	// The bridge must see a steady request for the whole operation.
	a_req_stable: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!s_rdy_i |=> $stable(s_req_o)
	);

	// Read data only shows up on a cycle that also ends the operation.
	a_data_on_rdy: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(s_data_i != '0) |-> s_rdy_i
	);

endmodule

// File: common/pi1_pkg.sv
// ********************
// Pi1 bridge types
// ********************

package pi1_pkg;

	// Bus geometry.
	localparam int ARCH_BITS = 32;
	localparam int SEL_BITS  = ARCH_BITS / 8;
	localparam int ADDR_BITS = ARCH_BITS - 2; // Word address, byte offset dropped.

	// Target memory.
	localparam int RAM_WORDS     = 256;
	localparam int RAM_ADDR_BITS = 8;

	// Operation codes on the pi1 port.
	typedef enum logic [1:0] {
		PI_NOP = 2'b00,
		PI_WR  = 2'b01,
		PI_RD  = 2'b10,
		PI_RW  = 2'b11 // Swap, read then write.
	} pi1_op_e;

	// One pi1 operation as presented by the master.
	typedef struct packed {
		pi1_op_e                op;
		logic [ADDR_BITS-1:0]   addr;
		logic [ARCH_BITS-1:0]   data;
		logic [SEL_BITS-1:0]    sel;
	} pi1_req_t;

	// Wishbone B4 request fields; cyc and stb travel separately.
	typedef struct packed {
		logic                   we;
		logic [ARCH_BITS-1:0]   addr; // Byte address.
		logic [ARCH_BITS-1:0]   data;
		logic [SEL_BITS-1:0]    sel;
	} wb4_req_t;

endpackage
